// ==== all.f ====
hdl/decode_pkg.sv
hdl/reg_file.sv
hdl/reg_scoreboard.sv
hdl/decode_control.sv
hdl/command_stage.sv
hdl/rv_decode_stage.sv
tests/rv_decode_stage_tb.sv

// ==== hdl/command_stage.sv ====
// One-entry registered valid/ready stage for the execute command
`timescale 1ns/100ps

module command_stage (
    input logic clk,
    input logic arst_n,
    input logic in_valid,
    input decode_pkg::execute_op_t in_command,
    input logic out_ready,
    output logic stage_ready,
    output logic out_valid,
    output decode_pkg::execute_op_t out_command
);

    logic valid_q;
    decode_pkg::execute_op_t command_q;

    // Accept when empty or when the held entry leaves this cycle
    assign stage_ready = !valid_q || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (stage_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_ready && in_valid) begin
            command_q <= in_command;
        end
    end

    assign out_valid = valid_q;
    assign out_command = command_q;

endmodule

// ==== hdl/decode_control.sv ====
// Decode control FSM with reset sweep, jump flag, opcode classes, issue, exit and retired count
`timescale 1ns/100ps

module decode_control (
    input logic clk,
    input logic arst_n,
    input logic instruction_valid,
    input decode_pkg::instruction_op_t instruction,
    input logic jump_valid,
    input logic jump_mispredicted,
    input logic operands_ready,
    input decode_pkg::reg_status_t rd_status,
    input decode_pkg::reg_value_t rs1_value,
    input decode_pkg::reg_value_t rs2_value,
    input logic stage_ready,
    output logic instruction_ready,
    output decode_pkg::reg_addr_t rs1_addr,
    output decode_pkg::reg_addr_t rs2_addr,
    output decode_pkg::reg_addr_t rd_addr,
    output logic sweep_clear,
    output decode_pkg::reg_addr_t sweep_addr,
    output logic issue_write,
    output logic issue,
    output decode_pkg::execute_op_t command,
    output logic exit_flag,
    output decode_pkg::exit_code_t exit_code,
    output logic [decode_pkg::RETIRED_WIDTH-1:0] retired_count
);

    typedef enum logic [1:0] {
        STATE_RESET,
        STATE_NORMAL,
        STATE_EXIT
    } state_t;

    state_t state;
    decode_pkg::reg_addr_t sweep_count;
    decode_pkg::jump_flag_t jump_flag;
    decode_pkg::jump_flag_t current_flag;
    decode_pkg::instr_word_u word;
    decode_pkg::exit_code_t next_exit_code;
    logic [6:0] opcode;
    logic is_env;
    logic is_ebreak;
    logic is_muldiv;
    logic is_float;
    logic is_illegal;
    logic writes_rd;
    logic stale;
    logic exit_now;
    logic send;

    assign word = instruction.word;
    assign opcode = word.itype.opcode;

    // A mispredict resolved this cycle already applies to the current instruction
    assign current_flag = jump_flag
        + decode_pkg::jump_flag_t'(jump_valid && jump_mispredicted);
    assign stale = (instruction.jump_flag != current_flag);

    always_comb begin
        is_float = 1'b0;
        is_illegal = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            decode_pkg::OPCODE_OP, decode_pkg::OPCODE_OP_IMM, decode_pkg::OPCODE_LOAD,
            decode_pkg::OPCODE_JAL, decode_pkg::OPCODE_JALR, decode_pkg::OPCODE_LUI,
            decode_pkg::OPCODE_AUIPC, decode_pkg::OPCODE_SYSTEM: writes_rd = 1'b1;
            decode_pkg::OPCODE_STORE, decode_pkg::OPCODE_BRANCH: writes_rd = 1'b0;
            decode_pkg::OPCODE_FLOAT_LOAD, decode_pkg::OPCODE_FLOAT_STORE,
            decode_pkg::OPCODE_FLOAT_OP: is_float = 1'b1;
            default: is_illegal = 1'b1;
        endcase
    end

    assign is_env = (opcode == decode_pkg::OPCODE_SYSTEM)
        && (word.itype.funct3 == decode_pkg::FUNCT3_PRIV);
    assign is_ebreak = is_env && (word.itype.imm == decode_pkg::FUNCT12_EBREAK);
    assign is_muldiv = (opcode == decode_pkg::OPCODE_OP)
        && (word.itype.imm[11:5] == decode_pkg::FUNCT7_MULDIV);
    assign exit_now = is_illegal || is_float || is_muldiv || is_ebreak;

    // Environment calls take their argument from a0
    assign rs1_addr = is_env ? decode_pkg::REG_A0 : word.itype.rs1;
    assign rs2_addr = is_env ? decode_pkg::REG_A0 : word.stype.rs2;
    assign rd_addr = (writes_rd && !exit_now) ? word.itype.rd : '0;

    always_comb begin
        case (state)
            STATE_NORMAL: instruction_ready = stale || (operands_ready && stage_ready);
            STATE_EXIT: instruction_ready = 1'b1;
            default: instruction_ready = 1'b0;
        endcase
    end

    assign send = instruction_valid && instruction_ready && (state == STATE_NORMAL) && !stale;
    assign issue = send;
    assign issue_write = send && (rd_addr != '0);

    always_comb begin
        if (is_ebreak) begin
            next_exit_code = rs1_value[7:0];
        end else if (is_float) begin
            next_exit_code = decode_pkg::EXIT_FLOAT;
        end else if (is_muldiv) begin
            next_exit_code = decode_pkg::EXIT_MULDIV;
        end else begin
            next_exit_code = decode_pkg::EXIT_ILLEGAL;
        end
    end

    always_comb begin
        command.opcode = opcode;
        command.funct3 = word.itype.funct3;
        command.funct7 = word.itype.imm[11:5];
        command.rd = rd_addr;
        command.rd_status = rd_status;
        command.rs1_value = rs1_value;
        command.rs2_value = rs2_value;
        // Stores split the immediate around rs2
        if (opcode == decode_pkg::OPCODE_STORE) begin
            command.imm = {{20{word.stype.imm_hi[6]}}, word.stype.imm_hi, word.stype.imm_lo};
        end else begin
            command.imm = {{20{word.itype.imm[11]}}, word.itype.imm};
        end
        command.jump_flag = current_flag;
        command.halt = exit_now;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= STATE_RESET;
            sweep_count <= '0;
            jump_flag <= '0;
            exit_code <= '0;
            retired_count <= '0;
        end else begin
            jump_flag <= current_flag;
            case (state)
                STATE_RESET: begin
                    sweep_count <= sweep_count + 1'b1;
                    if (sweep_count == decode_pkg::reg_addr_t'(decode_pkg::NUM_REGS - 1)) begin
                        state <= STATE_NORMAL;
                    end
                end
                STATE_NORMAL: begin
                    if (send && exit_now) begin
                        state <= STATE_EXIT;
                        exit_code <= next_exit_code;
                    end else if (send) begin
                        retired_count <= retired_count + 1'b1;
                    end
                end
                default: state <= state;
            endcase
        end
    end

    assign sweep_clear = (state == STATE_RESET);
    assign sweep_addr = sweep_count;
    assign exit_flag = (state == STATE_EXIT);

endmodule

// ==== hdl/decode_pkg.sv ====
// Decode stage package with widths, scalar types, RV32I opcodes, exit codes and port structs
package decode_pkg;

    localparam int NUM_REGS = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int XLEN = 32;
    localparam int REG_STATUS_WIDTH = 3;
    localparam int JUMP_FLAG_WIDTH = 2;
    localparam int RETIRED_WIDTH = 32;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [XLEN-1:0] reg_value_t;
    typedef logic [REG_STATUS_WIDTH-1:0] reg_status_t;
    typedef logic [JUMP_FLAG_WIDTH-1:0] jump_flag_t;
    typedef logic [7:0] exit_code_t;

    // RV32I base opcodes, plus the F extension ones that force an exit
    localparam logic [6:0] OPCODE_OP = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LOAD = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR = 7'b1100111;
    localparam logic [6:0] OPCODE_LUI = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC = 7'b0010111;
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;
    localparam logic [6:0] OPCODE_FLOAT_LOAD = 7'b0000111;
    localparam logic [6:0] OPCODE_FLOAT_STORE = 7'b0100111;
    localparam logic [6:0] OPCODE_FLOAT_OP = 7'b1010011;

    localparam logic [2:0] FUNCT3_PRIV = 3'b000;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
    localparam logic [11:0] FUNCT12_EBREAK = 12'h001;
    localparam reg_addr_t REG_A0 = 5'd10;

    localparam exit_code_t EXIT_ILLEGAL = 8'd1;
    localparam exit_code_t EXIT_FLOAT = 8'd2;
    localparam exit_code_t EXIT_MULDIV = 8'd3;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t rs1;
        logic [2:0] funct3;
        reg_addr_t rd;
        logic [6:0] opcode;
    } instr_itype_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t rs2;
        reg_addr_t rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_stype_t;

    // Same 32 bits, seen as I-type or S-type
    typedef union packed {
        instr_itype_t itype;
        instr_stype_t stype;
    } instr_word_u;

    typedef struct packed {
        instr_word_u word;
        jump_flag_t jump_flag;
    } instruction_op_t;

    typedef struct packed {
        reg_addr_t addr;
        reg_value_t value;
    } writeback_t;

    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        reg_addr_t rd;
        reg_status_t rd_status;
        reg_value_t rs1_value;
        reg_value_t rs2_value;
        reg_value_t imm;
        jump_flag_t jump_flag;
        logic halt;
    } execute_op_t;

endpackage

// ==== hdl/reg_file.sv ====
// Register file, 32 x 32 bits, one write port and two combinational read ports
`timescale 1ns/100ps

module reg_file (
    input logic clk,
    input logic arst_n,
    input logic write_enable,
    input decode_pkg::reg_addr_t write_addr,
    input decode_pkg::reg_value_t write_value,
    input decode_pkg::reg_addr_t rs1_addr,
    input decode_pkg::reg_addr_t rs2_addr,
    output decode_pkg::reg_value_t rs1_value,
    output decode_pkg::reg_value_t rs2_value
);

    decode_pkg::reg_value_t regs [decode_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < decode_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable) begin
            regs[write_addr] <= write_value;
        end
    end

    // x0 is hardwired to zero
    assign rs1_value = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_value = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hdl/reg_scoreboard.sv ====
// Register scoreboard with front and rear write counters and the operand-ready check
`timescale 1ns/100ps

module reg_scoreboard (
    input logic clk,
    input logic arst_n,
    input logic sweep_clear,
    input decode_pkg::reg_addr_t sweep_addr,
    input decode_pkg::reg_addr_t rs1_addr,
    input decode_pkg::reg_addr_t rs2_addr,
    input decode_pkg::reg_addr_t rd_addr,
    input logic issue_write,
    input logic writeback_valid,
    input decode_pkg::writeback_t writeback,
    output logic operands_ready,
    output decode_pkg::reg_status_t rd_status
);

    // Front counts issued writes, rear counts completed writebacks
    decode_pkg::reg_status_t front [decode_pkg::NUM_REGS];
    decode_pkg::reg_status_t rear [decode_pkg::NUM_REGS];

    logic rs1_clear;
    logic rs2_clear;
    logic rd_room;
    decode_pkg::reg_status_t rd_front_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < decode_pkg::NUM_REGS; i++) begin
                front[i] <= '0;
                rear[i] <= '0;
            end
        end else if (sweep_clear) begin
            front[sweep_addr] <= '0;
            rear[sweep_addr] <= '0;
        end else begin
            if (issue_write) begin
                front[rd_addr] <= front[rd_addr] + 1'b1;
            end
            // x0 never gets a pending write, so its writebacks are dropped
            if (writeback_valid && writeback.addr != '0) begin
                rear[writeback.addr] <= rear[writeback.addr] + 1'b1;
            end
        end
    end

    assign rs1_clear = (front[rs1_addr] == rear[rs1_addr]);
    assign rs2_clear = (front[rs2_addr] == rear[rs2_addr]);

    // One more write to rd must not wrap the front onto the rear
    assign rd_front_next = front[rd_addr] + 1'b1;
    assign rd_room = (rd_front_next != rear[rd_addr]);

    assign operands_ready = rs1_clear && rs2_clear && rd_room;
    assign rd_status = front[rd_addr];

endmodule

// ==== hdl/rv_decode_stage.sv ====
// RV32I decode stage top level with control, scoreboard, register file and command stage
`timescale 1ns/100ps

module rv_decode_stage (
    input logic clk,
    input logic arst_n,
    input logic instruction_valid,
    output logic instruction_ready,
    input decode_pkg::instruction_op_t instruction,
    output logic execute_valid,
    input logic execute_ready,
    output decode_pkg::execute_op_t execute_command,
    input logic writeback_valid,
    input decode_pkg::writeback_t writeback,
    input logic jump_valid,
    input logic jump_mispredicted,
    output logic exit_flag,
    output decode_pkg::exit_code_t exit_code,
    output logic [decode_pkg::RETIRED_WIDTH-1:0] retired_count
);

    decode_pkg::reg_addr_t rs1_addr;
    decode_pkg::reg_addr_t rs2_addr;
    decode_pkg::reg_addr_t rd_addr;
    decode_pkg::reg_addr_t sweep_addr;
    decode_pkg::reg_value_t rs1_value;
    decode_pkg::reg_value_t rs2_value;
    decode_pkg::reg_status_t rd_status;
    decode_pkg::execute_op_t command;
    logic sweep_clear;
    logic issue_write;
    logic issue;
    logic operands_ready;
    logic stage_ready;
    logic rf_write_enable;
    decode_pkg::reg_addr_t rf_write_addr;
    decode_pkg::reg_value_t rf_write_value;

    // Sweep owns the write port until it finishes
    assign rf_write_enable = sweep_clear || writeback_valid;
    assign rf_write_addr = sweep_clear ? sweep_addr : writeback.addr;
    assign rf_write_value = sweep_clear ? '0 : writeback.value;

    decode_control decode_control_inst (
        .clk(clk),
        .arst_n(arst_n),
        .instruction_valid(instruction_valid),
        .instruction(instruction),
        .jump_valid(jump_valid),
        .jump_mispredicted(jump_mispredicted),
        .operands_ready(operands_ready),
        .rd_status(rd_status),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .stage_ready(stage_ready),
        .instruction_ready(instruction_ready),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rd_addr(rd_addr),
        .sweep_clear(sweep_clear),
        .sweep_addr(sweep_addr),
        .issue_write(issue_write),
        .issue(issue),
        .command(command),
        .exit_flag(exit_flag),
        .exit_code(exit_code),
        .retired_count(retired_count)
    );

    reg_scoreboard reg_scoreboard_inst (
        .clk(clk),
        .arst_n(arst_n),
        .sweep_clear(sweep_clear),
        .sweep_addr(sweep_addr),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rd_addr(rd_addr),
        .issue_write(issue_write),
        .writeback_valid(writeback_valid),
        .writeback(writeback),
        .operands_ready(operands_ready),
        .rd_status(rd_status)
    );

    reg_file reg_file_inst (
        .clk(clk),
        .arst_n(arst_n),
        .write_enable(rf_write_enable),
        .write_addr(rf_write_addr),
        .write_value(rf_write_value),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value)
    );

    command_stage command_stage_inst (
        .clk(clk),
        .arst_n(arst_n),
        .in_valid(issue),
        .in_command(command),
        .out_ready(execute_ready),
        .stage_ready(stage_ready),
        .out_valid(execute_valid),
        .out_command(execute_command)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module rv_decode_stage_tb \
    -f all.f \
    --Mdir obj_dir -o sim

./obj_dir/sim > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0

// ==== tests/rv_decode_stage_tb.sv ====
// Testbench for rv_decode_stage with execute-unit model, writeback driver, monitor and watchdog
`timescale 1ns/100ps

module rv_decode_stage_tb;

    localparam int CLK_PERIOD = 20;
    // Five resets of about 45 cycles, about 110 instructions of up to 6 cycles each
    localparam int TEST_CYCLES = 5 * 45 + 110 * 6;
    localparam int MARGIN_CYCLES = 500;
    localparam int WAIT_LIMIT = 200;

    logic clk;
    logic arst_n;
    logic instruction_valid;
    logic instruction_ready;
    decode_pkg::instruction_op_t instruction;
    logic execute_valid;
    logic execute_ready;
    decode_pkg::execute_op_t execute_command;
    logic writeback_valid;
    decode_pkg::writeback_t writeback;
    logic jump_valid;
    logic jump_mispredicted;
    logic exit_flag;
    decode_pkg::exit_code_t exit_code;
    logic [decode_pkg::RETIRED_WIDTH-1:0] retired_count;

    // Model of the architectural state and of the commands still in flight
    decode_pkg::reg_value_t model [decode_pkg::NUM_REGS];
    // Issued writes per register since reset, wrapping like the front count
    decode_pkg::reg_status_t issued_writes [decode_pkg::NUM_REGS];
    decode_pkg::execute_op_t exp_q [$];
    decode_pkg::reg_addr_t pending_q [$];
    decode_pkg::jump_flag_t tb_flag;
    decode_pkg::exit_code_t exp_exit_code;
    logic [31:0] lfsr_state = 32'h3fa0e8aa;
    logic exited;
    logic rand_ready;
    int errors;
    int checks;
    int tests_run;
    int halt_count;
    int exp_retired;
    int test_start_errors;
    time last_accept;
    time wb_time;

    rv_decode_stage rv_decode_stage_inst (
        .clk(clk),
        .arst_n(arst_n),
        .instruction_valid(instruction_valid),
        .instruction_ready(instruction_ready),
        .instruction(instruction),
        .execute_valid(execute_valid),
        .execute_ready(execute_ready),
        .execute_command(execute_command),
        .writeback_valid(writeback_valid),
        .writeback(writeback),
        .jump_valid(jump_valid),
        .jump_mispredicted(jump_mispredicted),
        .exit_flag(exit_flag),
        .exit_code(exit_code),
        .retired_count(retired_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] itype(logic [6:0] op, logic [4:0] rd, logic [2:0] f3,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] stype(logic [6:0] op, logic [2:0] f3, logic [4:0] rs1,
                                          logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic logic [31:0] rtype(logic [6:0] op, logic [4:0] rd, logic [4:0] rs1,
                                          logic [4:0] rs2, logic [6:0] f7);
        return {f7, rs2, rs1, 3'b000, rd, op};
    endfunction

    // 0 for no exit, otherwise 1 illegal, 2 float, 3 mul/div, 4 ebreak
    function automatic int exit_kind(logic [31:0] w);
        case (w[6:0])
            decode_pkg::OPCODE_OP: return (w[31:25] == decode_pkg::FUNCT7_MULDIV) ? 3 : 0;
            decode_pkg::OPCODE_OP_IMM, decode_pkg::OPCODE_LOAD, decode_pkg::OPCODE_STORE,
            decode_pkg::OPCODE_BRANCH, decode_pkg::OPCODE_JAL, decode_pkg::OPCODE_JALR,
            decode_pkg::OPCODE_LUI, decode_pkg::OPCODE_AUIPC: return 0;
            decode_pkg::OPCODE_SYSTEM:
                return (w[14:12] == 3'b000 && w[31:20] == decode_pkg::FUNCT12_EBREAK) ? 4 : 0;
            decode_pkg::OPCODE_FLOAT_LOAD, decode_pkg::OPCODE_FLOAT_STORE,
            decode_pkg::OPCODE_FLOAT_OP: return 2;
            default: return 1;
        endcase
    endfunction

    function automatic logic writes_rd(logic [31:0] w);
        case (w[6:0])
            decode_pkg::OPCODE_OP, decode_pkg::OPCODE_OP_IMM, decode_pkg::OPCODE_LOAD,
            decode_pkg::OPCODE_JAL, decode_pkg::OPCODE_JALR, decode_pkg::OPCODE_LUI,
            decode_pkg::OPCODE_AUIPC, decode_pkg::OPCODE_SYSTEM: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        checks++;
        assert (cond) else begin
            $display("Failure at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic take_command(decode_pkg::execute_op_t got);
        decode_pkg::execute_op_t e;
        if (exp_q.size() == 0) begin
            check_true(1'b0, "a command came out with no issued instruction waiting");
            return;
        end
        e = exp_q.pop_front();
        check_value("execute_command.opcode", 32'(e.opcode), 32'(got.opcode));
        check_value("execute_command.funct3", 32'(e.funct3), 32'(got.funct3));
        check_value("execute_command.funct7", 32'(e.funct7), 32'(got.funct7));
        check_value("execute_command.rd", 32'(e.rd), 32'(got.rd));
        check_value("execute_command.rd_status", 32'(e.rd_status), 32'(got.rd_status));
        check_value("execute_command.rs1_value", e.rs1_value, got.rs1_value);
        check_value("execute_command.rs2_value", e.rs2_value, got.rs2_value);
        check_value("execute_command.imm", e.imm, got.imm);
        check_value("execute_command.jump_flag", 32'(e.jump_flag), 32'(got.jump_flag));
        check_value("execute_command.halt", 32'(e.halt), 32'(got.halt));
        if (got.halt) begin
            halt_count++;
        end else if (got.rd != '0) begin
            pending_q.push_back(got.rd);
        end
    endtask

    // Execute side: ready is driven on the falling edge, the transfer is seen just after
    initial begin
        execute_ready = 1'b1;
        forever begin
            @(negedge clk);
            execute_ready = rand_ready ? 1'(rand_bits(1)) : 1'b1;
            #1;
            if (arst_n && execute_valid && execute_ready) begin
                take_command(execute_command);
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    task automatic send(input logic [31:0] w, input decode_pkg::jump_flag_t f);
        int waited;
        int kind;
        decode_pkg::execute_op_t e;
        decode_pkg::reg_addr_t ra;
        decode_pkg::reg_addr_t rb;
        @(negedge clk);
        instruction_valid = 1'b1;
        instruction = {w, f};
        waited = 0;
        #1;
        while (!instruction_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!instruction_ready) begin
            check_true(1'b0, "an instruction was never accepted");
            @(negedge clk);
            instruction_valid = 1'b0;
            return;
        end
        if (f != tb_flag && !exited) begin
            check_true(waited == 0, "a stale instruction was not consumed at once");
        end
        kind = exit_kind(w);
        ra = (kind == 4) ? decode_pkg::REG_A0 : w[19:15];
        rb = (kind == 4) ? decode_pkg::REG_A0 : w[24:20];
        e = '0;
        e.opcode = w[6:0];
        e.funct3 = w[14:12];
        e.funct7 = w[31:25];
        e.rd = (writes_rd(w) && kind == 0) ? w[11:7] : '0;
        e.rd_status = issued_writes[e.rd];
        e.rs1_value = model[ra];
        e.rs2_value = model[rb];
        if (w[6:0] == decode_pkg::OPCODE_STORE) begin
            e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        end else begin
            e.imm = {{20{w[31]}}, w[31:20]};
        end
        e.jump_flag = f;
        e.halt = (kind != 0);
        @(posedge clk);
        last_accept = $time;
        if (!exited && f == tb_flag) begin
            exp_q.push_back(e);
            if (e.rd != '0) begin
                issued_writes[e.rd] = issued_writes[e.rd] + 1'b1;
            end
            if (kind != 0) begin
                exited = 1'b1;
                exp_exit_code = (kind == 4) ? model[decode_pkg::REG_A0][7:0] : 8'(kind);
            end else begin
                exp_retired++;
            end
        end
        @(negedge clk);
        instruction_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            #2;
            n++;
        end
        check_true(exp_q.size() == 0, "issued commands never came out");
    endtask

    // Results for every finished command with a destination, one per cycle
    task automatic drain_writebacks();
        decode_pkg::reg_addr_t rd;
        decode_pkg::reg_value_t v;
        wait_idle();
        while (pending_q.size() > 0) begin
            rd = pending_q.pop_front();
            v = rand_bits(32);
            @(negedge clk);
            writeback_valid = 1'b1;
            writeback = '{addr: rd, value: v};
            model[rd] = v;
        end
        @(negedge clk);
        writeback_valid = 1'b0;
    endtask

    task automatic write_x0(decode_pkg::reg_value_t v);
        @(negedge clk);
        writeback_valid = 1'b1;
        writeback = '{addr: 5'd0, value: v};
        @(negedge clk);
        writeback_valid = 1'b0;
    endtask

    task automatic pulse_jump(logic mispredicted);
        @(negedge clk);
        jump_valid = 1'b1;
        jump_mispredicted = mispredicted;
        @(negedge clk);
        jump_valid = 1'b0;
        jump_mispredicted = 1'b0;
        if (mispredicted) begin
            tb_flag = tb_flag + 1'b1;
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        arst_n = 1'b0;
        instruction_valid = 1'b0;
        writeback_valid = 1'b0;
        jump_valid = 1'b0;
        jump_mispredicted = 1'b0;
        rand_ready = 1'b0;
        exp_q.delete();
        pending_q.delete();
        exited = 1'b0;
        tb_flag = '0;
        exp_retired = 0;
        halt_count = 0;
        for (int i = 0; i < decode_pkg::NUM_REGS; i++) begin
            model[i] = '0;
            issued_writes[i] = '0;
        end
        repeat (8) @(negedge clk);
        check_value("execute_valid", 32'd0, 32'(execute_valid));
        check_value("exit_flag", 32'd0, 32'(exit_flag));
        check_value("instruction_ready", 32'd0, 32'(instruction_ready));
        check_value("retired_count", 32'd0, retired_count);
        arst_n = 1'b1;
        // Sweep of one register per cycle
        for (int i = 0; i < decode_pkg::NUM_REGS; i++) begin
            #1;
            check_value("instruction_ready", 32'd0, 32'(instruction_ready));
            @(negedge clk);
        end
        #1;
        check_value("instruction_ready", 32'd1, 32'(instruction_ready));
    endtask

    task automatic end_test(string name);
        drain_writebacks();
        @(negedge clk);
        #2;
        check_value("retired_count", 32'(exp_retired), retired_count);
        tests_run++;
        $display("Test %s finished with %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    task automatic run_exit(logic [31:0] w, string name);
        reset_dut();
        send(itype(decode_pkg::OPCODE_OP_IMM, 5'd10, 3'b000, 5'd0, 12'h000), tb_flag);
        drain_writebacks();
        send(w, tb_flag);
        send(itype(decode_pkg::OPCODE_OP_IMM, 5'd12, 3'b000, 5'd0, 12'h000), tb_flag);
        wait_idle();
        @(negedge clk);
        #2;
        check_value("exit_flag", 32'd1, 32'(exit_flag));
        check_value("exit_code", 32'(exp_exit_code), 32'(exit_code));
        check_value("halt command count", 32'd1, 32'(halt_count));
        end_test(name);
    endtask

    initial begin
        logic [31:0] r;
        arst_n = 1'b0;
        instruction_valid = 1'b0;
        instruction = '0;
        writeback_valid = 1'b0;
        writeback = '0;
        jump_valid = 1'b0;
        jump_mispredicted = 1'b0;
        rand_ready = 1'b0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        test_start_errors = 0;

        reset_dut();
        for (int i = 1; i < decode_pkg::NUM_REGS; i++) begin
            send(stype(decode_pkg::OPCODE_STORE, 3'b010, 5'(i), 5'(32 - i), 12'(i)), tb_flag);
        end
        end_test("sweep");

        for (int i = 1; i <= 5; i++) begin
            send(itype(decode_pkg::OPCODE_OP_IMM, 5'(i), 3'b000, 5'd0, {7'(i), 5'd0}), tb_flag);
        end
        drain_writebacks();
        write_x0(rand_bits(32));
        send(itype(decode_pkg::OPCODE_OP_IMM, 5'd9, 3'b000, 5'd0, 12'h000), tb_flag);
        send(stype(decode_pkg::OPCODE_STORE, 3'b010, 5'd1, 5'd2, 12'hf85), tb_flag);
        send(itype(decode_pkg::OPCODE_LOAD, 5'd6, 3'b010, 5'd3, 12'h800), tb_flag);
        end_test("operands and immediates");

        send(itype(decode_pkg::OPCODE_OP_IMM, 5'd7, 3'b000, 5'd0, 12'h000), tb_flag);
        wait_idle();
        fork
            send(rtype(decode_pkg::OPCODE_OP, 5'd8, 5'd7, 5'd1, 7'd0), tb_flag);
            begin
                repeat (6) @(negedge clk);
                wb_time = $time;
                drain_writebacks();
            end
        join
        check_true(last_accept > wb_time, "an instruction issued before its operand was written");
        end_test("stall on pending write");

        pulse_jump(1'b1);
        repeat (2) begin
            send(itype(decode_pkg::OPCODE_OP_IMM, 5'd11, 3'b000, 5'd0, 12'h000),
                 decode_pkg::jump_flag_t'(tb_flag - 1'b1));
        end
        repeat (2) begin
            send(itype(decode_pkg::OPCODE_OP_IMM, 5'd11, 3'b000, 5'd1, 12'h000), tb_flag);
        end
        pulse_jump(1'b0);
        send(stype(decode_pkg::OPCODE_STORE, 3'b010, 5'd2, 5'd3, 12'h010), tb_flag);
        end_test("jump flush");

        rand_ready = 1'b1;
        for (int i = 0; i < 40; i++) begin
            r = rand_bits(32);
            if (r[0]) begin
                send(stype(decode_pkg::OPCODE_STORE, 3'b010, r[5:1], r[10:6], r[22:11]), tb_flag);
            end else begin
                send(stype(decode_pkg::OPCODE_BRANCH, r[13:11], r[5:1], r[10:6], r[22:11]),
                     tb_flag);
            end
        end
        wait_idle();
        rand_ready = 1'b0;
        end_test("back-pressure");

        run_exit(itype(decode_pkg::OPCODE_SYSTEM, 5'd0, 3'b000, 5'd0,
                       decode_pkg::FUNCT12_EBREAK), "ebreak exit");
        run_exit(rtype(7'h7f, 5'd5, 5'd1, 5'd2, 7'd0), "illegal exit");
        run_exit(rtype(decode_pkg::OPCODE_FLOAT_OP, 5'd3, 5'd4, 5'd5, 7'd0), "float exit");
        run_exit(rtype(decode_pkg::OPCODE_OP, 5'd6, 5'd1, 5'd2, decode_pkg::FUNCT7_MULDIV),
                 "muldiv exit");

        $display("Tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
